// ==== ApuBusFsm.sv ====
module ApuBusFsm (
	input  logic CLK,
	input  logic rst,
	input  logic cycleStart,
	input  logic cycleEnd,
	input  apuBusPkg::wbReq_t wbReq,
	input  logic [7:0] rdData,
	output apuBusPkg::wbRsp_t wbRsp,
	output apuBusPkg::wbReq_t access,
	output logic busAct
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		ACTIVE
	} state_t;

	state_t state;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (wbReq.cyc && wbReq.stb) begin
						state <= WAIT;
					end
				end
				// A request waits here for the next CPU cycle boundary
				WAIT: begin
					if (cycleStart) begin
						state <= ACTIVE;
					end
				end
				ACTIVE: begin
					if (cycleEnd) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// The decoder sees this copy, so the address stays put for the whole CPU cycle
	always_ff @(posedge CLK) begin
		if (state == WAIT && cycleStart) begin
			access <= wbReq;
		end
	end

	assign busAct = state == ACTIVE;

	always_comb begin
		wbRsp.ack = busAct && cycleEnd;
		wbRsp.dat = rdData;
	end

	// The master keeps cyc and stb up from the request until it has taken the ack
	assert property (@(posedge CLK) disable iff (rst)
		state != IDLE |-> wbReq.cyc && wbReq.stb);

endmodule

// ==== ApuPhaseDivider.sv ====
module ApuPhaseDivider #(
	parameter int ClkDiv = 12
) (
	input  logic CLK,
	input  logic rst,
	output logic phi1,
	output logic cycleStart,
	output logic cycleEnd
);

	localparam int CntW = $clog2(ClkDiv);
	localparam logic [CntW-1:0] LastCount = CntW'(ClkDiv - 1);
	localparam logic [CntW-1:0] HalfCount = CntW'(ClkDiv / 2);

	logic [CntW-1:0] count;

	always_ff @(posedge CLK) begin
		if (rst || count == LastCount) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// PHI1 is the first half of the CPU cycle, PHI2 the second
	assign phi1 = count < HalfCount;
	assign cycleStart = count == '0;
	assign cycleEnd = count == LastCount;

endmodule

// ==== ApuReadMux.sv ====
module ApuReadMux (
	input  logic CLK,
	input  logic rst,
	input  logic cycleEnd,
	input  logic busAct,
	input  apuBusPkg::wbReq_t access,
	input  apuRegsPkg::readSel_t rdSel,
	input  logic [4:0] status,
	input  apuRegsPkg::pad_t pads,
	input  logic [7:0] dbg0,
	input  logic [7:0] dbg1,
	input  logic [7:0] dbg2,
	output logic [7:0] rdData
);

	// Last byte seen on the CPU data bus
	logic [7:0] openBus;

	always_comb begin
		case (rdSel)
			apuRegsPkg::RD_STATUS: rdData = {3'b000, status};
			// Controller ports only drive the low five bits
			apuRegsPkg::RD_PAD1: rdData = {openBus[7:5], pads.pad1};
			apuRegsPkg::RD_PAD2: rdData = {openBus[7:5], pads.pad2};
			apuRegsPkg::RD_DBG0: rdData = dbg0;
			apuRegsPkg::RD_DBG1: rdData = dbg1;
			apuRegsPkg::RD_DBG2: rdData = dbg2;
			default: rdData = openBus;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			openBus <= '0;
		end else if (cycleEnd && busAct) begin
			openBus <= access.we ? access.dat : rdData;
		end
	end

endmodule

// ==== ApuRegFile.sv ====
module ApuRegFile (
	input  logic CLK,
	input  logic rst,
	input  logic cycleEnd,
	input  apuRegsPkg::regStrobe_t strobe,
	input  logic [7:0] wrData,
	output apuRegsPkg::regWrite_t regWr,
	output logic [4:0] status,
	output logic [7:0] dbg0,
	output logic [7:0] dbg1,
	output logic [7:0] dbg2
);

	localparam logic [4:0] StatusIdx = 5'h15;
	localparam logic [4:0] Dbg0Idx = 5'h00;
	localparam logic [4:0] Dbg1Idx = 5'h04;

	logic [7:0] regs [32];
	logic [4:0] wrIdx;
	logic wrAny;
	logic evValid;
	logic [4:0] evIdx;
	logic [7:0] evData;

	// The strobe is one-hot, so a plain priority scan gives the index
	always_comb begin
		wrIdx = '0;
		for (int i = 0; i < 32; i++) begin
			if (strobe.wrMask[i]) begin
				wrIdx = 5'(i);
			end
		end
	end

	// The byte is taken on the last CLK of the CPU cycle late in PHI2
	assign wrAny = cycleEnd && |strobe.wrMask;

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			evValid <= 1'b0;
		end else begin
			evValid <= wrAny;
			if (wrAny) begin
				regs[wrIdx] <= wrData;
			end
		end
	end

	always_ff @(posedge CLK) begin
		evIdx <= wrIdx;
		evData <= wrData;
	end

	assign regWr = '{valid: evValid, idx: evIdx, data: evData};
	assign status = regs[StatusIdx][4:0];
	assign dbg0 = regs[Dbg0Idx];
	assign dbg1 = regs[Dbg1Idx];
	assign dbg2 = regs[apuRegsPkg::DbgWrIdx];

	// Only one register may take the data bus at a time
	assert property (@(posedge CLK) disable iff (rst) $onehot0(strobe.wrMask));

endmodule

// ==== ApuRegsBlock.sv ====
module ApuRegsBlock (
	input  apuBusPkg::wbReq_t access,
	input  logic busAct,
	input  logic phi1,
	input  logic dbg,
	output apuRegsPkg::regStrobe_t strobe
);

	// Registers 4000h to 4008h, 400Ah to 400Ch and 400Eh to 4017h take writes
	localparam logic [31:0] WrMap = 32'h00FF_DDFF;

	logic hit;
	logic wrHit;
	logic rdHit;
	logic [4:0] idx;
	logic [31:0] wrMask;

	assign hit = (access.adr & apuRegsPkg::RegMask) == apuRegsPkg::RegBase;
	assign idx = access.adr[4:0];

	// Writes are disabled during PHI1
	assign wrHit = busAct && hit && access.we && !phi1;
	assign rdHit = busAct && hit && !access.we;

	always_comb begin
		for (int i = 0; i < 32; i++) begin
			wrMask[i] = wrHit && (idx == 5'(i)) &&
				(WrMap[i] || (dbg && 5'(i) == apuRegsPkg::DbgWrIdx));
		end
	end

	always_comb begin
		strobe.wrMask = wrMask;
		strobe.rdSel = apuRegsPkg::RD_OPEN;
		if (rdHit) begin
			case (idx)
				5'h15: strobe.rdSel = apuRegsPkg::RD_STATUS;
				5'h16: strobe.rdSel = apuRegsPkg::RD_PAD1;
				5'h17: strobe.rdSel = apuRegsPkg::RD_PAD2;
				// Debug registers read as open bus unless the debug pad is set
				5'h18: begin
					if (dbg) begin
						strobe.rdSel = apuRegsPkg::RD_DBG0;
					end
				end
				5'h19: begin
					if (dbg) begin
						strobe.rdSel = apuRegsPkg::RD_DBG1;
					end
				end
				5'h1A: begin
					if (dbg) begin
						strobe.rdSel = apuRegsPkg::RD_DBG2;
					end
				end
				default: strobe.rdSel = apuRegsPkg::RD_OPEN;
			endcase
		end
	end

endmodule

// ==== ApuRegsTop.sv ====
module ApuRegsTop #(
	parameter int ClkDiv = 12
) (
	input  logic CLK,
	input  logic rst,
	input  apuBusPkg::wbReq_t wbReq,
	input  apuRegsPkg::pad_t pads,
	input  logic dbg,
	output apuBusPkg::wbRsp_t wbRsp,
	output apuRegsPkg::regWrite_t regWr
);

	logic phi1;
	logic cycleStart;
	logic cycleEnd;
	logic busAct;
	apuBusPkg::wbReq_t access;
	apuRegsPkg::regStrobe_t strobe;
	logic [7:0] rdData;
	logic [4:0] status;
	logic [7:0] dbg0;
	logic [7:0] dbg1;
	logic [7:0] dbg2;

	ApuPhaseDivider #(.ClkDiv(ClkDiv)) i_ApuPhaseDivider (
		.CLK(CLK), .rst(rst), .phi1(phi1), .cycleStart(cycleStart), .cycleEnd(cycleEnd)
	);

	ApuBusFsm i_ApuBusFsm (
		.CLK(CLK), .rst(rst), .cycleStart(cycleStart), .cycleEnd(cycleEnd),
		.wbReq(wbReq), .rdData(rdData), .wbRsp(wbRsp), .access(access), .busAct(busAct)
	);

	ApuRegsBlock i_ApuRegsBlock (
		.access(access), .busAct(busAct), .phi1(phi1), .dbg(dbg), .strobe(strobe)
	);

	// Write data comes from the latched access, not the live bus
	ApuRegFile i_ApuRegFile (
		.CLK(CLK), .rst(rst), .cycleEnd(cycleEnd), .strobe(strobe), .wrData(access.dat),
		.regWr(regWr), .status(status), .dbg0(dbg0), .dbg1(dbg1), .dbg2(dbg2)
	);

	ApuReadMux i_ApuReadMux (
		.CLK(CLK), .rst(rst), .cycleEnd(cycleEnd), .busAct(busAct), .access(access),
		.rdSel(strobe.rdSel), .status(status), .pads(pads),
		.dbg0(dbg0), .dbg1(dbg1), .dbg2(dbg2), .rdData(rdData)
	);

endmodule

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/VtbApuRegs: filelist.f *.sv
	verilator --binary --timing --assert -f filelist.f --top-module tbApuRegs

run: obj_dir/VtbApuRegs
	@out="$$(./obj_dir/VtbApuRegs)"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module tbApuRegs

clean:
	rm -rf obj_dir

// ==== apuBusPkg.sv ====
package apuBusPkg;

	// CPU master request, held stable by the master until it sees ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [15:0] adr;
		logic [7:0] dat;
	} wbReq_t;

	// Slave response, ack lasts one CLK cycle and carries the read byte
	typedef struct packed {
		logic ack;
		logic [7:0] dat;
	} wbRsp_t;

endpackage

// ==== apuRegsPkg.sv ====
package apuRegsPkg;

	// The register window covers 4000h to 401Fh
	localparam logic [15:0] RegBase = 16'h4000;
	localparam logic [15:0] RegMask = 16'hFFE0;

	// Register 401Ah can only be written in debug mode
	localparam logic [4:0] DbgWrIdx = 5'h1A;

	typedef enum logic [2:0] {
		RD_OPEN,
		RD_STATUS,
		RD_PAD1,
		RD_PAD2,
		RD_DBG0,
		RD_DBG1,
		RD_DBG2
	} readSel_t;

	// One write strobe per register, indexed by address bits 4:0
	typedef struct packed {
		logic [31:0] wrMask;
		readSel_t rdSel;
	} regStrobe_t;

	typedef struct packed {
		logic [4:0] pad1;
		logic [4:0] pad2;
	} pad_t;

	// Write event sent toward the sound channels
	typedef struct packed {
		logic valid;
		logic [4:0] idx;
		logic [7:0] data;
	} regWrite_t;

endpackage

// ==== filelist.f ====
apuBusPkg.sv
apuRegsPkg.sv
ApuPhaseDivider.sv
ApuBusFsm.sv
ApuRegsBlock.sv
ApuRegFile.sv
ApuReadMux.sv
ApuRegsTop.sv
tbApuRegs.sv

// ==== tbApuRegs.sv ====
module tbApuRegs;

	localparam int ClkDiv = 12;
	localparam int NumReq = 400;
	localparam int CycleLimit = NumReq * (2 * ClkDiv + 4);

	logic CLK;
	logic rst;
	apuBusPkg::wbReq_t wbReq;
	apuRegsPkg::pad_t pads;
	logic dbg;
	apuBusPkg::wbRsp_t wbRsp;
	apuRegsPkg::regWrite_t regWr;

	logic [31:0] lfsr;
	logic dbgOn;
	logic [7:0] modelRegs [32];
	logic [7:0] modelOpenBus;
	int cycleCount = 0;
	int ackErrors;
	int readErrors;
	int eventErrors;

	ApuRegsTop #(.ClkDiv(ClkDiv)) i_ApuRegsTop (
		.CLK(CLK), .rst(rst), .wbReq(wbReq), .pads(pads), .dbg(dbg),
		.wbRsp(wbRsp), .regWr(regWr)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	// Galois LFSR, one step for every bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return value;
	endfunction

	function automatic logic inWindow(input logic [15:0] adr);
		return (adr & 16'hFFE0) == 16'h4000;
	endfunction

	// Write map of the unit, 401Ah only in debug mode
	function automatic logic isWritable(input logic [4:0] idx, input logic dbgMode);
		return idx <= 5'h08 || (idx >= 5'h0A && idx <= 5'h0C) ||
			(idx >= 5'h0E && idx <= 5'h17) || (dbgMode && idx == 5'h1A);
	endfunction

	function automatic logic [7:0] expectedRead(input logic [15:0] adr,
		input apuRegsPkg::pad_t padIn, input logic dbgMode);
		logic [7:0] value;
		value = modelOpenBus;
		if (inWindow(adr)) begin
			case (adr[4:0])
				5'h15: value = {3'b000, modelRegs[5'h15][4:0]};
				5'h16: value = {modelOpenBus[7:5], padIn.pad1};
				5'h17: value = {modelOpenBus[7:5], padIn.pad2};
				5'h18: value = dbgMode ? modelRegs[5'h00] : modelOpenBus;
				5'h19: value = dbgMode ? modelRegs[5'h04] : modelOpenBus;
				5'h1A: value = dbgMode ? modelRegs[5'h1A] : modelOpenBus;
				default: value = modelOpenBus;
			endcase
		end
		return value;
	endfunction

	task automatic runRequest(input int n);
		apuBusPkg::wbReq_t req;
		apuRegsPkg::pad_t padVal;
		logic [7:0] expData;
		logic expEvent;
		logic sawAck;
		int lat;
		if (n % 50 == 0) begin
			if (1'(randBits(1))) begin
				dbgOn = !dbgOn;
			end
		end
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = 1'(randBits(1));
		// About 70% of the accesses land in the register window
		if (randBits(7) < 32'd90) begin
			req.adr = 16'h4000 | 16'(randBits(5));
		end else begin
			req.adr = 16'(randBits(16));
		end
		req.dat = 8'(randBits(8));
		padVal.pad1 = 5'(randBits(5));
		padVal.pad2 = 5'(randBits(5));
		expData = expectedRead(req.adr, padVal, dbgOn);
		expEvent = req.we && inWindow(req.adr) && isWritable(req.adr[4:0], dbgOn);

		@(posedge CLK);
		wbReq <= req;
		pads <= padVal;
		dbg <= dbgOn;

		lat = 0;
		sawAck = 1'b0;
		while (!sawAck) begin
			@(negedge CLK);
			lat++;
			if (regWr.valid) begin
				$display("[ERROR] %0t: write event while access to %h is pending", $time, req.adr);
				eventErrors++;
			end
			if (wbRsp.ack) begin
				sawAck = 1'b1;
			end
		end
		if (lat < ClkDiv || lat > 2 * ClkDiv) begin
			$display("[ERROR] %0t: ack for %h after %0d cycles", $time, req.adr, lat);
			ackErrors++;
		end
		if (!req.we && wbRsp.dat !== expData) begin
			$display("[ERROR] %0t: read of %h returned %h, expected %h",
				$time, req.adr, wbRsp.dat, expData);
			readErrors++;
		end

		// Master releases the bus on the edge that takes the ack
		@(posedge CLK);
		wbReq <= '0;
		@(negedge CLK);
		if (wbRsp.ack) begin
			$display("[ERROR] %0t: second ack for access to %h", $time, req.adr);
			ackErrors++;
		end
		if (regWr.valid !== expEvent) begin
			$display("[ERROR] %0t: write event valid %b for %h, expected %b",
				$time, regWr.valid, req.adr, expEvent);
			eventErrors++;
		end else if (expEvent && (regWr.idx !== req.adr[4:0] || regWr.data !== req.dat)) begin
			$display("[ERROR] %0t: write event %h/%h, expected %h/%h",
				$time, regWr.idx, regWr.data, req.adr[4:0], req.dat);
			eventErrors++;
		end

		if (req.we) begin
			if (expEvent) begin
				modelRegs[req.adr[4:0]] = req.dat;
			end
			modelOpenBus = req.dat;
		end else begin
			modelOpenBus = expData;
		end
	endtask

	initial begin
		lfsr = 32'hecc5_ac68;
		rst = 1'b1;
		wbReq = '0;
		pads = '0;
		dbg = 1'b0;
		dbgOn = 1'b0;
		modelOpenBus = '0;
		ackErrors = 0;
		readErrors = 0;
		eventErrors = 0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		repeat (4) @(posedge CLK);
		rst <= 1'b0;
		for (int n = 0; n < NumReq; n++) begin
			runRequest(n);
		end
		$display("Errors: ack %0d, read %0d, event %0d", ackErrors, readErrors, eventErrors);
		if (ackErrors + readErrors + eventErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
